// File: logic/greenhouse_pkg.sv
package greenhouse_pkg;

	// Unsigned temperature in whole degrees
	localparam int TEMP_W = 8;

	// Signed temperature threshold
	localparam int TH_W = 8;

	// Light level and tracker dead band
	localparam int LUX_W = 16;

	// Segments a through g
	localparam int SEG_W = 7;

	// Anodes per display
	localparam int DIGIT_N = 4;

	// Active high patterns with bit 6 as a and bit 0 as g
	localparam logic [SEG_W-1:0] seg_table [0:9] = '{
		7'h7e,
		7'h30,
		7'h6d,
		7'h79,
		7'h33,
		7'h5b,
		7'h5f,
		7'h70,
		7'h7f,
		7'h7b
	};

	// Unused digit stays dark
	localparam logic [SEG_W-1:0] SEG_BLANK = 7'h00;

endpackage

// File: logic/sensor_capture.sv
`timescale 1ns/1ps

module sensor_capture (
	input  logic                              clk,
	input  logic                              arst_n,
	input  logic                              sample,
	input  logic [greenhouse_pkg::TEMP_W-1:0] solar_celcius,
	input  logic [greenhouse_pkg::TEMP_W-1:0] greenhouse_celcius,
	input  logic [greenhouse_pkg::TEMP_W-1:0] ambient_celcius,
	input  logic [greenhouse_pkg::TEMP_W-1:0] geothermal_celcius,
	input  logic [greenhouse_pkg::LUX_W-1:0]  n_lux,
	input  logic [greenhouse_pkg::LUX_W-1:0]  e_lux,
	input  logic [greenhouse_pkg::LUX_W-1:0]  s_lux,
	input  logic [greenhouse_pkg::LUX_W-1:0]  w_lux,
	output logic [greenhouse_pkg::TEMP_W-1:0] solar_celcius_q,
	output logic [greenhouse_pkg::TEMP_W-1:0] greenhouse_celcius_q,
	output logic [greenhouse_pkg::TEMP_W-1:0] ambient_celcius_q,
	output logic [greenhouse_pkg::TEMP_W-1:0] geothermal_celcius_q,
	output logic [greenhouse_pkg::LUX_W-1:0]  n_lux_q,
	output logic [greenhouse_pkg::LUX_W-1:0]  e_lux_q,
	output logic [greenhouse_pkg::LUX_W-1:0]  s_lux_q,
	output logic [greenhouse_pkg::LUX_W-1:0]  w_lux_q,
	output logic                              sample_seen
);

	// Whole snapshot is taken on one strobe so all readings belong together.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			solar_celcius_q      <= '0;
			greenhouse_celcius_q <= '0;
			ambient_celcius_q    <= '0;
			geothermal_celcius_q <= '0;
			n_lux_q              <= '0;
			e_lux_q              <= '0;
			s_lux_q              <= '0;
			w_lux_q              <= '0;
		end else if (sample) begin
			solar_celcius_q      <= solar_celcius;
			greenhouse_celcius_q <= greenhouse_celcius;
			ambient_celcius_q    <= ambient_celcius;
			geothermal_celcius_q <= geothermal_celcius;
			n_lux_q              <= n_lux;
			e_lux_q              <= e_lux;
			s_lux_q              <= s_lux;
			w_lux_q              <= w_lux;
		end
	end

	// Sticky until reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sample_seen <= 1'b0;
		end else if (sample) begin
			sample_seen <= 1'b1;
		end
	end

endmodule

// File: logic/heat_exchange_control.sv
`timescale 1ns/1ps

module heat_exchange_control (
	input  logic                                    clk,
	input  logic                                    arst_n,
	input  logic                                    sample_seen,
	input  logic        [greenhouse_pkg::TEMP_W-1:0] greenhouse_temp,
	input  logic        [greenhouse_pkg::TEMP_W-1:0] source_temp,
	input  logic signed [greenhouse_pkg::TH_W-1:0]   cooldown_th,
	input  logic signed [greenhouse_pkg::TH_W-1:0]   heatup_th,
	output logic                                    enable
);

	// One extra bit so unsigned readings compare against negative thresholds
	localparam int CMP_W = greenhouse_pkg::TEMP_W + 1;

	logic signed [CMP_W-1:0] gh_s;
	logic signed [CMP_W-1:0] src_s;
	logic signed [CMP_W-1:0] cool_s;
	logic signed [CMP_W-1:0] heat_s;
	logic                    src_colder;
	logic                    src_warmer;
	logic                    cool_demand;
	logic                    heat_demand;

	assign gh_s   = $signed({1'b0, greenhouse_temp});
	assign src_s  = $signed({1'b0, source_temp});
	assign cool_s = CMP_W'(cooldown_th);
	assign heat_s = CMP_W'(heatup_th);

	assign src_colder = src_s < gh_s;
	assign src_warmer = src_s > gh_s;

	// Too warm inside and the source can take heat away
	assign cool_demand = (gh_s > cool_s) && src_colder;
	// Too cold inside and the source can bring heat in
	assign heat_demand = (gh_s < heat_s) && src_warmer;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			enable <= 1'b0;
		end else begin
			enable <= sample_seen && (cool_demand || heat_demand);
		end
	end

endmodule

// File: logic/solar_tracker.sv
`timescale 1ns/1ps

module solar_tracker (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             sample_seen,
	input  logic [greenhouse_pkg::LUX_W-1:0] n_lux,
	input  logic [greenhouse_pkg::LUX_W-1:0] e_lux,
	input  logic [greenhouse_pkg::LUX_W-1:0] s_lux,
	input  logic [greenhouse_pkg::LUX_W-1:0] w_lux,
	input  logic [greenhouse_pkg::LUX_W-1:0] dead_band,
	output logic                             move_north,
	output logic                             move_east,
	output logic                             move_south,
	output logic                             move_west
);

	// Difference of two unsigned levels fits in one extra signed bit
	localparam int DIFF_W = greenhouse_pkg::LUX_W + 1;

	logic signed [DIFF_W-1:0] n_s;
	logic signed [DIFF_W-1:0] e_s;
	logic signed [DIFF_W-1:0] s_s;
	logic signed [DIFF_W-1:0] w_s;
	logic signed [DIFF_W-1:0] band_s;
	logic signed [DIFF_W-1:0] ns_diff;
	logic signed [DIFF_W-1:0] sn_diff;
	logic signed [DIFF_W-1:0] ew_diff;
	logic signed [DIFF_W-1:0] we_diff;

	assign n_s    = $signed({1'b0, n_lux});
	assign e_s    = $signed({1'b0, e_lux});
	assign s_s    = $signed({1'b0, s_lux});
	assign w_s    = $signed({1'b0, w_lux});
	assign band_s = $signed({1'b0, dead_band});

	assign ns_diff = n_s - s_s;
	assign sn_diff = s_s - n_s;
	assign ew_diff = e_s - w_s;
	assign we_diff = w_s - e_s;

	// Band is never negative, so at most one of each pair can pass
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			move_north <= 1'b0;
			move_east  <= 1'b0;
			move_south <= 1'b0;
			move_west  <= 1'b0;
		end else begin
			move_north <= sample_seen && (ns_diff > band_s);
			move_south <= sample_seen && (sn_diff > band_s);
			move_east  <= sample_seen && (ew_diff > band_s);
			move_west  <= sample_seen && (we_diff > band_s);
		end
	end

endmodule

// File: logic/seven_segment_controller.sv
`timescale 1ns/1ps

module seven_segment_controller #(
	parameter int unsigned REFRESH_CYCLES = 4
) (
	input  logic                               clk,
	input  logic                               arst_n,
	input  logic [greenhouse_pkg::TEMP_W-1:0]  binary,
	output logic [greenhouse_pkg::DIGIT_N-1:0] anode_en,
	output logic [greenhouse_pkg::SEG_W-1:0]   segments
);

	localparam int CNT_W = (REFRESH_CYCLES > 1) ? $clog2(REFRESH_CYCLES) : 1;
	localparam int IDX_W = $clog2(greenhouse_pkg::DIGIT_N);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(REFRESH_CYCLES - 1);

	logic [CNT_W-1:0]                 refresh_cnt;
	logic                             tick;
	logic                             scan_on;
	logic [IDX_W-1:0]                 digit_idx;
	logic [IDX_W-1:0]                 digit_next;
	logic [IDX_W-1:0]                 sel_idx;
	logic [3:0]                       ones;
	logic [3:0]                       tens;
	logic [3:0]                       hundreds;
	logic [greenhouse_pkg::SEG_W-1:0] pattern;

	assign tick = refresh_cnt == CNT_LAST;

	// First tick lights anode 0, later ticks step through the rest
	assign digit_next = scan_on ? digit_idx + 1'b1 : '0;

	// Digit that is lit in the next cycle
	assign sel_idx = tick ? digit_next : digit_idx;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			refresh_cnt <= '0;
		end else if (tick) begin
			refresh_cnt <= '0;
		end else begin
			refresh_cnt <= refresh_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			scan_on   <= 1'b0;
			digit_idx <= '0;
			anode_en  <= '0;
		end else if (tick) begin
			scan_on   <= 1'b1;
			digit_idx <= digit_next;
			anode_en  <= greenhouse_pkg::DIGIT_N'(1) << digit_next;
		end
	end

	// Constant divisors, so no divider core is needed
	assign hundreds = 4'(binary / 8'd100);
	assign tens     = 4'((binary / 8'd10) % 8'd10);
	assign ones     = 4'(binary % 8'd10);

	always_comb begin
		case (sel_idx)
			2'd0:    pattern = greenhouse_pkg::seg_table[ones];
			2'd1:    pattern = greenhouse_pkg::seg_table[tens];
			2'd2:    pattern = greenhouse_pkg::seg_table[hundreds];
			default: pattern = greenhouse_pkg::SEG_BLANK;
		endcase
	end

	// Follows the value every cycle, not only when the anode moves
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			segments <= greenhouse_pkg::SEG_BLANK;
		end else if (scan_on || tick) begin
			segments <= pattern;
		end
	end

endmodule

// File: logic/greenhouse_ctrl.sv
`timescale 1ns/1ps

module greenhouse_ctrl #(
	parameter int unsigned REFRESH_CYCLES = 4
) (
	input  logic                                     clk,
	input  logic                                     arst_n,
	input  logic                                     sample,
	input  logic        [greenhouse_pkg::TEMP_W-1:0]  solar_celcius,
	input  logic        [greenhouse_pkg::TEMP_W-1:0]  greenhouse_celcius,
	input  logic        [greenhouse_pkg::TEMP_W-1:0]  ambient_celcius,
	input  logic        [greenhouse_pkg::TEMP_W-1:0]  geothermal_celcius,
	input  logic        [greenhouse_pkg::LUX_W-1:0]   n_lux,
	input  logic        [greenhouse_pkg::LUX_W-1:0]   e_lux,
	input  logic        [greenhouse_pkg::LUX_W-1:0]   s_lux,
	input  logic        [greenhouse_pkg::LUX_W-1:0]   w_lux,
	input  logic        [greenhouse_pkg::LUX_W-1:0]   solar_th,
	input  logic signed [greenhouse_pkg::TH_W-1:0]    solar_cooldown_th,
	input  logic signed [greenhouse_pkg::TH_W-1:0]    solar_heatup_th,
	input  logic signed [greenhouse_pkg::TH_W-1:0]    ambient_cooldown_th,
	input  logic signed [greenhouse_pkg::TH_W-1:0]    ambient_heatup_th,
	input  logic signed [greenhouse_pkg::TH_W-1:0]    geothermal_cooldown_th,
	input  logic signed [greenhouse_pkg::TH_W-1:0]    geothermal_heatup_th,
	output logic                                     window_open,
	output logic                                     fan_on,
	output logic                                     geothermal_on,
	output logic                                     solarheater_on,
	output logic                                     move_north,
	output logic                                     move_east,
	output logic                                     move_south,
	output logic                                     move_west,
	output logic        [greenhouse_pkg::DIGIT_N-1:0] solar_anode_en,
	output logic        [greenhouse_pkg::SEG_W-1:0]   solar_segments,
	output logic        [greenhouse_pkg::DIGIT_N-1:0] greenhouse_anode_en,
	output logic        [greenhouse_pkg::SEG_W-1:0]   greenhouse_segments,
	output logic        [greenhouse_pkg::DIGIT_N-1:0] ambient_anode_en,
	output logic        [greenhouse_pkg::SEG_W-1:0]   ambient_segments,
	output logic        [greenhouse_pkg::DIGIT_N-1:0] geothermal_anode_en,
	output logic        [greenhouse_pkg::SEG_W-1:0]   geothermal_segments
);

	logic [greenhouse_pkg::TEMP_W-1:0] solar_celcius_q;
	logic [greenhouse_pkg::TEMP_W-1:0] greenhouse_celcius_q;
	logic [greenhouse_pkg::TEMP_W-1:0] ambient_celcius_q;
	logic [greenhouse_pkg::TEMP_W-1:0] geothermal_celcius_q;
	logic [greenhouse_pkg::LUX_W-1:0]  n_lux_q;
	logic [greenhouse_pkg::LUX_W-1:0]  e_lux_q;
	logic [greenhouse_pkg::LUX_W-1:0]  s_lux_q;
	logic [greenhouse_pkg::LUX_W-1:0]  w_lux_q;
	logic                              sample_seen;

	// Window opens whenever the fan runs
	assign window_open = fan_on;

	sensor_capture i_capture (
		.clk                  (clk),
		.arst_n               (arst_n),
		.sample               (sample),
		.solar_celcius        (solar_celcius),
		.greenhouse_celcius   (greenhouse_celcius),
		.ambient_celcius      (ambient_celcius),
		.geothermal_celcius   (geothermal_celcius),
		.n_lux                (n_lux),
		.e_lux                (e_lux),
		.s_lux                (s_lux),
		.w_lux                (w_lux),
		.solar_celcius_q      (solar_celcius_q),
		.greenhouse_celcius_q (greenhouse_celcius_q),
		.ambient_celcius_q    (ambient_celcius_q),
		.geothermal_celcius_q (geothermal_celcius_q),
		.n_lux_q              (n_lux_q),
		.e_lux_q              (e_lux_q),
		.s_lux_q              (s_lux_q),
		.w_lux_q              (w_lux_q),
		.sample_seen          (sample_seen)
	);

	// Fan against ambient air
	heat_exchange_control i_fan_ctrl (
		.clk             (clk),
		.arst_n          (arst_n),
		.sample_seen     (sample_seen),
		.greenhouse_temp (greenhouse_celcius_q),
		.source_temp     (ambient_celcius_q),
		.cooldown_th     (ambient_cooldown_th),
		.heatup_th       (ambient_heatup_th),
		.enable          (fan_on)
	);

	heat_exchange_control i_geothermal_ctrl (
		.clk             (clk),
		.arst_n          (arst_n),
		.sample_seen     (sample_seen),
		.greenhouse_temp (greenhouse_celcius_q),
		.source_temp     (geothermal_celcius_q),
		.cooldown_th     (geothermal_cooldown_th),
		.heatup_th       (geothermal_heatup_th),
		.enable          (geothermal_on)
	);

	// Solar heater compares the panel temperature against itself as the inside reading
	heat_exchange_control i_solarheater_ctrl (
		.clk             (clk),
		.arst_n          (arst_n),
		.sample_seen     (sample_seen),
		.greenhouse_temp (solar_celcius_q),
		.source_temp     (solar_celcius_q),
		.cooldown_th     (solar_cooldown_th),
		.heatup_th       (solar_heatup_th),
		.enable          (solarheater_on)
	);

	solar_tracker i_tracker (
		.clk         (clk),
		.arst_n      (arst_n),
		.sample_seen (sample_seen),
		.n_lux       (n_lux_q),
		.e_lux       (e_lux_q),
		.s_lux       (s_lux_q),
		.w_lux       (w_lux_q),
		.dead_band   (solar_th),
		.move_north  (move_north),
		.move_east   (move_east),
		.move_south  (move_south),
		.move_west   (move_west)
	);

	seven_segment_controller #(.REFRESH_CYCLES(REFRESH_CYCLES)) i_solar_disp (
		.clk      (clk),
		.arst_n   (arst_n),
		.binary   (solar_celcius_q),
		.anode_en (solar_anode_en),
		.segments (solar_segments)
	);

	seven_segment_controller #(.REFRESH_CYCLES(REFRESH_CYCLES)) i_greenhouse_disp (
		.clk      (clk),
		.arst_n   (arst_n),
		.binary   (greenhouse_celcius_q),
		.anode_en (greenhouse_anode_en),
		.segments (greenhouse_segments)
	);

	seven_segment_controller #(.REFRESH_CYCLES(REFRESH_CYCLES)) i_ambient_disp (
		.clk      (clk),
		.arst_n   (arst_n),
		.binary   (ambient_celcius_q),
		.anode_en (ambient_anode_en),
		.segments (ambient_segments)
	);

	seven_segment_controller #(.REFRESH_CYCLES(REFRESH_CYCLES)) i_geothermal_disp (
		.clk      (clk),
		.arst_n   (arst_n),
		.binary   (geothermal_celcius_q),
		.anode_en (geothermal_anode_en),
		.segments (geothermal_segments)
	);

endmodule

// File: tb/greenhouse_ctrl_tb.sv
`timescale 1ns/1ps

module greenhouse_ctrl_tb;

	localparam int REFRESH = 4;
	localparam int SAMPLES = 300;
	localparam int MAX_GAP = 10;
	localparam int CYCLE_LIMIT = SAMPLES * MAX_GAP + 200;

	// Segment patterns for digits 0 to 9 with bit 6 as segment a
	localparam logic [6:0] seg_ref [0:9] = '{
		7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33,
		7'h5b, 7'h5f, 7'h70, 7'h7f, 7'h7b
	};

	logic clk;
	logic arst_n;
	logic sample;
	logic [7:0] solar_celcius, greenhouse_celcius, ambient_celcius, geothermal_celcius;
	logic [15:0] n_lux, e_lux, s_lux, w_lux, solar_th;
	logic signed [7:0] solar_cooldown_th, solar_heatup_th;
	logic signed [7:0] ambient_cooldown_th, ambient_heatup_th;
	logic signed [7:0] geothermal_cooldown_th, geothermal_heatup_th;
	logic window_open, fan_on, geothermal_on, solarheater_on;
	logic move_north, move_east, move_south, move_west;
	logic [3:0] solar_anode_en, greenhouse_anode_en, ambient_anode_en, geothermal_anode_en;
	logic [6:0] solar_segments, greenhouse_segments, ambient_segments, geothermal_segments;

	// Model state with temps ordered solar, greenhouse, ambient, geothermal
	logic [7:0] m_temp [4];
	logic [7:0] m_prev [4];
	logic [15:0] m_lux [4];
	logic m_seen;
	logic m_fan, m_geo, m_sheat, m_n, m_e, m_s, m_w;
	int m_scan;
	int errors = 0;
	int cycles = 0;
	int gap;

	greenhouse_ctrl #(.REFRESH_CYCLES(REFRESH)) i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic exchange_on(int gh, int src, int cool, int heat);
		return ((gh > cool) && (src < gh)) || ((gh < heat) && (src > gh));
	endfunction

	function automatic logic lux_move(int a, int b, int band);
		return (a - b) > band;
	endfunction

	task automatic check_val(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s expected %h actual %h at %0t", name, expected, actual, $time);
			errors++;
		end
	endtask

	task automatic check_display(input string name, input logic [3:0] anode,
			input logic [6:0] seg, input logic [7:0] value);
		logic [3:0] exp_anode;
		logic [6:0] exp_seg;
		int idx;
		int v;
		exp_anode = '0;
		exp_seg = 7'h00;
		v = int'(value);
		if (m_scan >= REFRESH) begin
			idx = (m_scan / REFRESH - 1) % 4;
			exp_anode = 4'b0001 << idx;
			case (idx)
				0: exp_seg = seg_ref[v % 10];
				1: exp_seg = seg_ref[(v / 10) % 10];
				2: exp_seg = seg_ref[v / 100];
				default: exp_seg = 7'h00;
			endcase
		end
		if ($countones(anode) > 1) begin
			$display("%s display has more than one anode on at %0t", name, $time);
			errors++;
		end
		check_val({name, "_anode_en"}, 32'(exp_anode), 32'(anode));
		check_val({name, "_segments"}, 32'(exp_seg), 32'(seg));
	endtask

	task automatic drive_noise();
		solar_celcius = 8'($urandom);
		greenhouse_celcius = 8'($urandom);
		ambient_celcius = 8'($urandom);
		geothermal_celcius = 8'($urandom);
		n_lux = 16'($urandom);
		e_lux = 16'($urandom);
		s_lux = 16'($urandom);
		w_lux = 16'($urandom);
		sample = 1'b0;
	endtask

	task automatic drive_sample(input bit edge_case);
		logic [7:0] t;
		logic [15:0] band;
		logic [15:0] base;
		t = 8'($urandom_range(0, 126));
		band = 16'($urandom_range(0, 16'h3fff));
		base = 16'($urandom_range(0, 16'hbfff));
		if (edge_case) begin
			// Equal readings, thresholds on the reading, light at the band edge
			{solar_celcius, greenhouse_celcius, ambient_celcius} = {t, t, t};
			geothermal_celcius = 8'($urandom);
			{ambient_cooldown_th, ambient_heatup_th} = {t, t};
			{solar_cooldown_th, solar_heatup_th} = {t, t};
			geothermal_cooldown_th = t;
			geothermal_heatup_th = t + 8'd1;
			solar_th = band;
			{s_lux, e_lux} = {base, base};
			n_lux = base + band;
			w_lux = base + band;
		end else begin
			drive_noise();
			solar_cooldown_th = 8'($urandom);
			solar_heatup_th = 8'($urandom);
			ambient_cooldown_th = 8'($urandom);
			ambient_heatup_th = 8'($urandom);
			geothermal_cooldown_th = 8'($urandom);
			geothermal_heatup_th = 8'($urandom);
			solar_th = 16'($urandom_range(0, 4095));
		end
		sample = 1'b1;
	endtask

	// Reference model, one step per clock edge
	always @(posedge clk) begin
		if (!arst_n) begin
			{m_seen, m_fan, m_geo, m_sheat, m_n, m_e, m_s, m_w} = '0;
			m_scan = 0;
			for (int i = 0; i < 4; i++) begin
				m_temp[i] = '0;
				m_prev[i] = '0;
				m_lux[i] = '0;
			end
		end else begin
			m_fan = m_seen && exchange_on(int'(m_temp[1]), int'(m_temp[2]),
				int'(ambient_cooldown_th), int'(ambient_heatup_th));
			m_geo = m_seen && exchange_on(int'(m_temp[1]), int'(m_temp[3]),
				int'(geothermal_cooldown_th), int'(geothermal_heatup_th));
			m_sheat = m_seen && exchange_on(int'(m_temp[0]), int'(m_temp[0]),
				int'(solar_cooldown_th), int'(solar_heatup_th));
			m_n = m_seen && lux_move(int'(m_lux[0]), int'(m_lux[2]), int'(solar_th));
			m_s = m_seen && lux_move(int'(m_lux[2]), int'(m_lux[0]), int'(solar_th));
			m_e = m_seen && lux_move(int'(m_lux[1]), int'(m_lux[3]), int'(solar_th));
			m_w = m_seen && lux_move(int'(m_lux[3]), int'(m_lux[1]), int'(solar_th));
			for (int i = 0; i < 4; i++) begin
				m_prev[i] = m_temp[i];
			end
			if (sample) begin
				m_temp[0] = solar_celcius;
				m_temp[1] = greenhouse_celcius;
				m_temp[2] = ambient_celcius;
				m_temp[3] = geothermal_celcius;
				m_lux[0] = n_lux;
				m_lux[1] = e_lux;
				m_lux[2] = s_lux;
				m_lux[3] = w_lux;
				m_seen = 1'b1;
			end
			m_scan = m_scan + 1;
		end
	end

	// Outputs are settled by the falling edge
	always @(negedge clk) begin
		if (arst_n) begin
			check_val("fan_on", 32'(m_fan), 32'(fan_on));
			check_val("window_open", 32'(m_fan), 32'(window_open));
			check_val("geothermal_on", 32'(m_geo), 32'(geothermal_on));
			check_val("solarheater_on", 32'(m_sheat), 32'(solarheater_on));
			check_val("move_north", 32'(m_n), 32'(move_north));
			check_val("move_east", 32'(m_e), 32'(move_east));
			check_val("move_south", 32'(m_s), 32'(move_south));
			check_val("move_west", 32'(m_w), 32'(move_west));
			if (move_north && move_south) begin
				$display("North and south moves both on at %0t", $time);
				errors++;
			end
			if (move_east && move_west) begin
				$display("East and west moves both on at %0t", $time);
				errors++;
			end
			check_display("solar", solar_anode_en, solar_segments, m_prev[0]);
			check_display("greenhouse", greenhouse_anode_en, greenhouse_segments, m_prev[1]);
			check_display("ambient", ambient_anode_en, ambient_segments, m_prev[2]);
			check_display("geothermal", geothermal_anode_en, geothermal_segments, m_prev[3]);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		arst_n = 1'b0;
		sample = 1'b0;
		{solar_celcius, greenhouse_celcius, ambient_celcius, geothermal_celcius} = '0;
		{n_lux, e_lux, s_lux, w_lux, solar_th} = '0;
		{solar_cooldown_th, solar_heatup_th} = '0;
		{ambient_cooldown_th, ambient_heatup_th} = '0;
		{geothermal_cooldown_th, geothermal_heatup_th} = '0;
		void'($urandom(32'hcb75_93c8));
		repeat (3) @(posedge clk);
		#10 arst_n = 1'b1;
		// Idle stretch before the first strobe
		repeat (6) @(posedge clk);
		for (int i = 0; i < SAMPLES; i++) begin
			gap = $urandom_range(3, MAX_GAP);
			repeat (gap - 1) begin
				@(posedge clk);
				#10;
				drive_noise();
			end
			@(posedge clk);
			#10;
			drive_sample(i % 6 == 5);
		end
		@(posedge clk);
		#10 sample = 1'b0;
		repeat (20) @(posedge clk);
		@(negedge clk);
		#1;
		$display("Run complete, %0d samples, %0d errors", SAMPLES, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: greenhouse_ctrl.f
logic/greenhouse_pkg.sv
logic/sensor_capture.sv
logic/heat_exchange_control.sv
logic/solar_tracker.sv
logic/seven_segment_controller.sv
logic/greenhouse_ctrl.sv
tb/greenhouse_ctrl_tb.sv

// File: Makefile
SIM      = verilator
TOP      = greenhouse_ctrl_tb
FILELIST = greenhouse_ctrl.f
FLAGS    = --binary --timing -j 0 --top-module $(TOP)
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
